//--- rvDecoder_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and special register numbers of the RV32I decoder.
// Register numbers are sized to REG_NUM_WIDTH, so keep them below 32.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RV_DECODER_SETTINGS_SVH
`define RV_DECODER_SETTINGS_SVH

// Instruction word
`define INSN_WIDTH 32

// Logical register number
`define REG_NUM_WIDTH 5

// Immediate after sign extension
`define DATA_WIDTH 32

// Writes to x0 are dropped
`define ZERO_REG 5'd0

// Link register for call and return hints
`define LINK_REG 5'd1

`endif

//--- rvDecodePkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the three decoder stages and the testbench.
// An all-zero microOpT is an ALU ADD with COND_AL and REG operands.
// The opcode class needs 4 bits since it has ten values.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rvDecoder_settings.svh"

package rvDecodePkg;

    typedef logic [`INSN_WIDTH-1:0] insnT;
    typedef logic [`REG_NUM_WIDTH-1:0] regNumT;
    typedef logic [`DATA_WIDTH-1:0] dataT;

    // Major opcodes that the decoder accepts
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcodeT;

    typedef enum logic [3:0] {
        CLS_OP, CLS_OP_IMM, CLS_LUI, CLS_AUIPC, CLS_BRANCH,
        CLS_JAL, CLS_JALR, CLS_LOAD, CLS_STORE, CLS_ILLEGAL
    } opClassT;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND, ALU_PASS_B
    } aluCodeT;

    typedef enum logic [1:0] {SHIFT_NONE, SHIFT_LSL, SHIFT_LSR, SHIFT_ASR} shiftKindT;

    typedef enum logic [2:0] {
        MOP_ALU, MOP_SHIFT, MOP_BR, MOP_RIJ, MOP_LOAD, MOP_STORE, MOP_ENV
    } mopTypeT;

    typedef enum logic [2:0] {
        COND_AL, COND_EQ, COND_NE, COND_LT, COND_GE, COND_LTU, COND_GEU
    } condCodeT;

    typedef enum logic [1:0] {OPK_REG, OPK_IMM, OPK_PC} operandKindT;

    typedef enum logic {ENV_INSN_ILLEGAL, ENV_INSN_VIOLATION} envCodeT;

    // Encoded as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} memSizeT;

    typedef struct packed {
        logic    isUnsigned;
        memSizeT size;
    } memModeT;

    // Stage 1 output
    typedef struct packed {
        logic       valid;
        opClassT    cls;
        regNumT     rd;
        regNumT     rs1;
        regNumT     rs2;
        logic [2:0] funct3;
        logic [6:0] funct7;
        insnT       insn;
        logic       illegalPC;
    } insnFieldsT;

    typedef struct packed {
        logic                      valid;
        mopTypeT                   mopType;
        aluCodeT                   aluCode;
        shiftKindT                 shiftKind;
        logic [`REG_NUM_WIDTH-1:0] shamt;
        condCodeT                  cond;
        operandKindT               opTypeA;
        operandKindT               opTypeB;
        regNumT                    dst;
        regNumT                    srcA;
        regNumT                    srcB;
        dataT                      imm;
        logic                      writeReg;
        memModeT                   memMode;
        logic                      isRASPush;
        logic                      isRASPop;
        envCodeT                   envCode;
        logic                      serialized;
        logic                      undefined;
    } microOpT;

    // Stage 2 output
    typedef struct packed {
        microOpT op;
        logic    illegalPC;
    } stage2T;

    typedef struct packed {
        logic writePC;
        logic isCall;
        logic isReturn;
        logic isRelBranch;
        logic isSerialized;
    } insnInfoT;

endpackage

//--- insnFieldSplit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoder stage 1. One register, accepts an instruction every cycle.
// Only valid is reset. Other fields are stale while valid is low.
// MISC-MEM, SYSTEM and every unknown opcode map to CLS_ILLEGAL.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rvDecoder_settings.svh"

module insnFieldSplit
    import rvDecodePkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inValid,
    input  logic [`INSN_WIDTH-1:0] insn,
    input  logic                   illegalPC,
    output insnFieldsT             fields
);

    insnFieldsT nextFields;
    opClassT    cls;

    // Opcode to class
    always_comb begin
        case (insn[6:0])
            OPC_OP:     cls = CLS_OP;
            OPC_OP_IMM: cls = CLS_OP_IMM;
            OPC_LUI:    cls = CLS_LUI;
            OPC_AUIPC:  cls = CLS_AUIPC;
            OPC_BRANCH: cls = CLS_BRANCH;
            OPC_JAL:    cls = CLS_JAL;
            OPC_JALR:   cls = CLS_JALR;
            OPC_LOAD:   cls = CLS_LOAD;
            OPC_STORE:  cls = CLS_STORE;
            default:    cls = CLS_ILLEGAL;
        endcase
    end

    // Standard RV32I field positions
    always_comb begin
        nextFields.valid     = inValid;
        nextFields.cls       = cls;
        nextFields.rd        = insn[11:7];
        nextFields.funct3    = insn[14:12];
        nextFields.rs1       = insn[19:15];
        nextFields.rs2       = insn[24:20];
        nextFields.funct7    = insn[31:25];
        nextFields.insn      = insn;
        nextFields.illegalPC = illegalPC;
    end

    always_ff @(posedge clk) begin
        fields <= nextFields;
        if (rst) begin
            fields.valid <= 1'b0;
        end
    end

endmodule

//--- opDecodeStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoder stage 2. Builds one micro-op per instruction in one cycle.
// Bad funct3/funct7 encodings only raise undefined here.
// The exception micro-op itself is formed in stage 3.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rvDecoder_settings.svh"

module opDecodeStage
    import rvDecodePkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  insnFieldsT fields,
    output stage2T     decoded
);

    microOpT op;
    stage2T  nextDecoded;
    dataT    immI;
    dataT    immS;
    dataT    immB;
    dataT    immU;
    dataT    immJ;
    logic    isShift;
    logic    funct7Zero;
    logic    funct7Alt;

    function automatic aluCodeT aluFromFunct3(input logic [2:0] funct3, input logic sub);
        aluCodeT code;
        case (funct3)
            3'd0:    code = sub ? ALU_SUB : ALU_ADD;
            3'd2:    code = ALU_SLT;
            3'd3:    code = ALU_SLTU;
            3'd4:    code = ALU_XOR;
            3'd6:    code = ALU_OR;
            3'd7:    code = ALU_AND;
            // Shifts go to the shifter, ALU code unused
            default: code = ALU_ADD;
        endcase
        return code;
    endfunction

    function automatic shiftKindT shiftFromFunct3(input logic [2:0] funct3, input logic arith);
        shiftKindT kind;
        case (funct3)
            3'd1:    kind = SHIFT_LSL;
            3'd5:    kind = arith ? SHIFT_ASR : SHIFT_LSR;
            default: kind = SHIFT_NONE;
        endcase
        return kind;
    endfunction

    // Sign-extended immediates of every format
    assign immI = {{(`DATA_WIDTH-12){fields.insn[31]}}, fields.insn[31:20]};
    assign immS = {{(`DATA_WIDTH-12){fields.insn[31]}}, fields.insn[31:25], fields.insn[11:7]};
    assign immB = {{(`DATA_WIDTH-13){fields.insn[31]}}, fields.insn[31], fields.insn[7],
                   fields.insn[30:25], fields.insn[11:8], 1'b0};
    assign immU = {{(`DATA_WIDTH-32){fields.insn[31]}}, fields.insn[31:12], 12'b0};
    assign immJ = {{(`DATA_WIDTH-21){fields.insn[31]}}, fields.insn[31], fields.insn[19:12],
                   fields.insn[20], fields.insn[30:21], 1'b0};

    assign isShift    = (fields.funct3 == 3'd1) || (fields.funct3 == 3'd5);
    assign funct7Zero = (fields.funct7 == 7'h00);
    assign funct7Alt  = (fields.funct7 == 7'h20);

    always_comb begin
        // Zero gives ALU ADD, COND_AL, REG operands
        op          = '0;
        op.valid    = fields.valid;
        op.dst      = fields.rd;
        op.srcA     = fields.rs1;
        op.srcB     = fields.rs2;
        op.opTypeB  = OPK_IMM;
        op.writeReg = (fields.rd != `ZERO_REG);

        case (fields.cls)
            CLS_OP: begin
                op.opTypeB   = OPK_REG;
                op.mopType   = isShift ? MOP_SHIFT : MOP_ALU;
                op.aluCode   = aluFromFunct3(fields.funct3, funct7Alt);
                op.shiftKind = shiftFromFunct3(fields.funct3, funct7Alt);
                op.shamt     = isShift ? fields.rs2 : '0;
                // Only ADD/SUB and SRL/SRA have a 0x20 form
                op.undefined = !(funct7Zero || funct7Alt)
                    || (funct7Alt && !(fields.funct3 inside {3'd0, 3'd5}));
            end
            CLS_OP_IMM: begin
                op.srcB      = '0;
                op.mopType   = isShift ? MOP_SHIFT : MOP_ALU;
                op.aluCode   = aluFromFunct3(fields.funct3, 1'b0);
                op.shiftKind = shiftFromFunct3(fields.funct3, funct7Alt);
                op.shamt     = isShift ? fields.rs2 : '0;
                op.imm       = isShift ? dataT'(fields.rs2) : immI;
                op.undefined = ((fields.funct3 == 3'd5) && !(funct7Zero || funct7Alt))
                    || ((fields.funct3 == 3'd1) && !funct7Zero);
            end
            CLS_LUI: begin
                op.aluCode = ALU_PASS_B;
                op.srcA    = `ZERO_REG;
                op.srcB    = '0;
                op.imm     = immU;
            end
            CLS_AUIPC: begin
                op.opTypeA = OPK_PC;
                op.srcA    = '0;
                op.srcB    = '0;
                op.imm     = immU;
            end
            CLS_BRANCH: begin
                op.mopType  = MOP_BR;
                op.opTypeB  = OPK_REG;
                op.dst      = '0;
                op.writeReg = 1'b0;
                op.imm      = immB;
                case (fields.funct3)
                    3'd0:    op.cond = COND_EQ;
                    3'd1:    op.cond = COND_NE;
                    3'd4:    op.cond = COND_LT;
                    3'd5:    op.cond = COND_GE;
                    3'd6:    op.cond = COND_LTU;
                    3'd7:    op.cond = COND_GEU;
                    default: op.undefined = 1'b1;
                endcase
            end
            CLS_JAL: begin
                op.mopType   = MOP_BR;
                op.opTypeA   = OPK_PC;
                op.srcA      = '0;
                op.srcB      = '0;
                op.imm       = immJ;
                op.isRASPush = (fields.rd == `LINK_REG);
            end
            CLS_JALR: begin
                op.mopType   = MOP_RIJ;
                op.srcB      = '0;
                op.imm       = immI;
                op.isRASPush = (fields.rd == `LINK_REG);
                op.isRASPop  = (fields.rd != `LINK_REG) && (fields.rs1 == `LINK_REG);
                op.undefined = (fields.funct3 != 3'd0);
            end
            CLS_LOAD: begin
                op.mopType            = MOP_LOAD;
                op.srcB               = '0;
                op.imm                = immI;
                op.memMode.isUnsigned = fields.funct3[2];
                op.memMode.size       = memSizeT'(fields.funct3[1:0]);
                op.undefined          = fields.funct3 inside {3'd3, 3'd6, 3'd7};
            end
            CLS_STORE: begin
                op.mopType      = MOP_STORE;
                op.opTypeB      = OPK_REG;
                op.dst          = '0;
                op.writeReg     = 1'b0;
                op.imm          = immS;
                op.memMode.size = memSizeT'(fields.funct3[1:0]);
                op.undefined    = (fields.funct3 > 3'd2);
            end
            default: begin
                op.undefined = 1'b1;
            end
        endcase

        nextDecoded.op        = op;
        nextDecoded.illegalPC = fields.illegalPC;
    end

    always_ff @(posedge clk) begin
        decoded <= nextDecoded;
        if (rst) begin
            decoded.op.valid <= 1'b0;
        end
    end

endmodule

//--- illegalCheckStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoder stage 3. Swaps in the exception micro-op and forms insnInfo.
// insnInfo reads all zero in any cycle where microOp.valid is low.
// Fetch violation takes priority over an undefined encoding.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rvDecoder_settings.svh"

module illegalCheckStage
    import rvDecodePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  stage2T   decoded,
    output microOpT  microOp,
    output insnInfoT insnInfo
);

    microOpT  nextOp;
    insnInfoT nextInfo;
    logic     isException;

    assign isException = decoded.op.undefined || decoded.illegalPC;

    always_comb begin
        nextInfo = '0;
        if (isException) begin
            // No register access, serialized
            nextOp            = '0;
            nextOp.valid      = decoded.op.valid;
            nextOp.mopType    = MOP_ENV;
            nextOp.opTypeA    = OPK_IMM;
            nextOp.opTypeB    = OPK_IMM;
            nextOp.serialized = 1'b1;
            nextOp.envCode    = decoded.illegalPC ? ENV_INSN_VIOLATION : ENV_INSN_ILLEGAL;

            nextInfo.isSerialized = 1'b1;
        end else begin
            nextOp = decoded.op;

            // BR covers both conditional branches and JAL
            nextInfo.writePC     = decoded.op.mopType inside {MOP_BR, MOP_RIJ};
            nextInfo.isRelBranch = (decoded.op.mopType == MOP_BR);
            nextInfo.isCall      = nextInfo.writePC && decoded.op.writeReg
                && (decoded.op.dst == `LINK_REG);
            nextInfo.isReturn    = (decoded.op.mopType == MOP_RIJ)
                && (decoded.op.srcA == `LINK_REG) && (decoded.op.dst == `ZERO_REG);
        end
    end

    always_ff @(posedge clk) begin
        microOp <= nextOp;
        if (rst) begin
            microOp.valid <= 1'b0;
            insnInfo      <= '0;
        end else begin
            insnInfo <= decoded.op.valid ? nextInfo : '0;
        end
    end

endmodule

//--- rvDecoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Three-stage RV32I decoder. No back-pressure, one instruction per cycle.
// Output appears exactly 3 cycles after inValid is sampled high.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rvDecoder_settings.svh"

module rvDecoder
    import rvDecodePkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inValid,
    input  logic [`INSN_WIDTH-1:0] insn,
    input  logic                   illegalPC,
    output microOpT                microOp,
    output insnInfoT               insnInfo
);

    insnFieldsT fields;
    stage2T     decoded;

    insnFieldSplit i_insnFieldSplit (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .insn      (insn),
        .illegalPC (illegalPC),
        .fields    (fields)
    );

    opDecodeStage i_opDecodeStage (
        .clk     (clk),
        .rst     (rst),
        .fields  (fields),
        .decoded (decoded)
    );

    illegalCheckStage i_illegalCheckStage (
        .clk      (clk),
        .rst      (rst),
        .decoded  (decoded),
        .microOp  (microOp),
        .insnInfo (insnInfo)
    );

endmodule

//--- rvDecoderTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the three-stage RV32I decoder. No reset is applied mid-run.
// One expectation is queued per clock after reset, valid or not.
// Outputs are compared on the falling edge, when they are stable.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "rvDecoder_settings.svh"

module rvDecoderTb
    import rvDecodePkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        microOpT  op;
        insnInfoT info;
        logic     useSrcA;
        logic     useSrcB;
        logic     useImm;
    } expectT;

    logic     clk;
    logic     rst;
    logic     inValid;
    insnT     insn;
    logic     illegalPC;
    microOpT  microOp;
    insnInfoT insnInfo;

    expectT expQ[$];
    int     errorCount = 0;
    int     checkCount = 0;
    int     testCount = 0;
    int     failedTests = 0;
    int     errorMark = 0;
    int     issuedCount = 0;
    int     checkedCount = 0;
    logic   seenOutput = 1'b0;
    int     seedDummy;

    rvDecoder i_dut (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .insn      (insn),
        .illegalPC (illegalPC),
        .microOp   (microOp),
        .insnInfo  (insnInfo)
    );

    always #5 clk = ~clk;

    // Reference model of the decode rules
    function automatic expectT expectFor(input insnT w, input logic badPC, input logic valid);
        expectT     e;
        logic [2:0] f3;
        logic [6:0] f7;
        regNumT     rd;
        regNumT     rs1;
        logic       isShift;
        logic       bad;
        f3          = w[14:12];
        f7          = w[31:25];
        rd          = w[11:7];
        rs1         = w[19:15];
        isShift     = (f3 == 3'd1) || (f3 == 3'd5);
        bad         = 1'b0;
        e           = '0;
        e.op.valid  = valid;
        e.op.dst    = rd;
        e.op.srcA   = rs1;
        e.op.srcB   = w[24:20];
        e.op.shamt  = w[24:20];
        e.op.opTypeB = OPK_IMM;
        e.op.imm    = 32'($signed(w[31:20]));
        e.op.writeReg = (rd != `ZERO_REG);
        e.useSrcA   = 1'b1;
        e.useImm    = 1'b1;
        case (w[6:0])
            OPC_OP, OPC_OP_IMM: begin
                e.op.mopType = isShift ? MOP_SHIFT : MOP_ALU;
                case (f3)
                    3'd0:    e.op.aluCode = (w[5] && f7 == 7'h20) ? ALU_SUB : ALU_ADD;
                    3'd2:    e.op.aluCode = ALU_SLT;
                    3'd3:    e.op.aluCode = ALU_SLTU;
                    3'd4:    e.op.aluCode = ALU_XOR;
                    3'd6:    e.op.aluCode = ALU_OR;
                    3'd7:    e.op.aluCode = ALU_AND;
                    default: e.op.aluCode = ALU_ADD;
                endcase
                if (f3 == 3'd1)
                    e.op.shiftKind = SHIFT_LSL;
                else if (f3 == 3'd5)
                    e.op.shiftKind = (f7 == 7'h20) ? SHIFT_ASR : SHIFT_LSR;
                // Bit 5 of the opcode tells OP from OP-IMM
                if (w[5]) begin
                    e.op.opTypeB = OPK_REG;
                    e.useSrcB    = 1'b1;
                    e.useImm     = 1'b0;
                    bad = !(f7 == 7'h00 || f7 == 7'h20)
                        || (f7 == 7'h20 && f3 != 3'd0 && f3 != 3'd5);
                end else begin
                    e.useImm = !isShift;
                    bad = (f3 == 3'd1 && f7 != 7'h00)
                        || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
                end
            end
            OPC_LUI: begin
                e.op.aluCode = ALU_PASS_B;
                e.op.srcA    = `ZERO_REG;
                e.op.imm     = {w[31:12], 12'h000};
            end
            OPC_AUIPC: begin
                e.op.opTypeA = OPK_PC;
                e.useSrcA    = 1'b0;
                e.op.imm     = {w[31:12], 12'h000};
            end
            OPC_BRANCH: begin
                e.op.mopType  = MOP_BR;
                e.op.opTypeB  = OPK_REG;
                e.useSrcB     = 1'b1;
                e.op.writeReg = 1'b0;
                e.op.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
                case (f3)
                    3'd0:    e.op.cond = COND_EQ;
                    3'd1:    e.op.cond = COND_NE;
                    3'd4:    e.op.cond = COND_LT;
                    3'd5:    e.op.cond = COND_GE;
                    3'd6:    e.op.cond = COND_LTU;
                    3'd7:    e.op.cond = COND_GEU;
                    default: bad = 1'b1;
                endcase
            end
            OPC_JAL: begin
                e.op.mopType   = MOP_BR;
                e.op.opTypeA   = OPK_PC;
                e.useSrcA      = 1'b0;
                e.op.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
                e.op.isRASPush = (rd == `LINK_REG);
            end
            OPC_JALR: begin
                e.op.mopType   = MOP_RIJ;
                e.op.isRASPush = (rd == `LINK_REG);
                e.op.isRASPop  = (rd != `LINK_REG) && (rs1 == `LINK_REG);
                bad            = (f3 != 3'd0);
            end
            OPC_LOAD: begin
                e.op.mopType            = MOP_LOAD;
                e.op.memMode.isUnsigned = f3[2];
                e.op.memMode.size       = memSizeT'(f3[1:0]);
                bad = (f3 == 3'd3) || (f3 == 3'd6) || (f3 == 3'd7);
            end
            OPC_STORE: begin
                e.op.mopType      = MOP_STORE;
                e.op.opTypeB      = OPK_REG;
                e.useSrcB         = 1'b1;
                e.op.writeReg     = 1'b0;
                e.op.imm          = 32'($signed({w[31:25], w[11:7]}));
                e.op.memMode.size = memSizeT'(f3[1:0]);
                bad               = (f3 > 3'd2);
            end
            default: bad = 1'b1;
        endcase
        if (bad || badPC) begin
            e                   = '0;
            e.op.valid          = valid;
            e.op.mopType        = MOP_ENV;
            e.op.opTypeA        = OPK_IMM;
            e.op.opTypeB        = OPK_IMM;
            e.op.serialized     = 1'b1;
            e.op.envCode        = badPC ? ENV_INSN_VIOLATION : ENV_INSN_ILLEGAL;
            e.info.isSerialized = 1'b1;
        end else begin
            e.info.writePC     = w[6:0] inside {OPC_BRANCH, OPC_JAL, OPC_JALR};
            e.info.isRelBranch = w[6:0] inside {OPC_BRANCH, OPC_JAL};
            e.info.isCall      = (w[6:0] inside {OPC_JAL, OPC_JALR}) && (rd == `LINK_REG);
            e.info.isReturn    = (w[6:0] == OPC_JALR) && (rs1 == `LINK_REG)
                && (rd == `ZERO_REG);
        end
        return e;
    endfunction

    task automatic checkField(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected)
        else begin
            $display("[ERROR] %s expected 0x%h actual 0x%h at %0t", name, expected, actual,
                     $time);
            errorCount++;
        end
    endtask

    task automatic compareOp(input expectT e);
        checkField("microOp.mopType", 32'(e.op.mopType), 32'(microOp.mopType));
        checkField("microOp.writeReg", 32'(e.op.writeReg), 32'(microOp.writeReg));
        checkField("microOp.opTypeA", 32'(e.op.opTypeA), 32'(microOp.opTypeA));
        checkField("microOp.opTypeB", 32'(e.op.opTypeB), 32'(microOp.opTypeB));
        checkField("microOp.serialized", 32'(e.op.serialized), 32'(microOp.serialized));
        checkField("microOp.undefined", 32'(e.op.undefined), 32'(microOp.undefined));
        checkField("insnInfo", {27'd0, e.info}, {27'd0, insnInfo});
        if (e.op.mopType == MOP_ENV) begin
            checkField("microOp.envCode", 32'(e.op.envCode), 32'(microOp.envCode));
        end else begin
            if (e.op.writeReg)
                checkField("microOp.dst", 32'(e.op.dst), 32'(microOp.dst));
            if (e.useSrcA)
                checkField("microOp.srcA", 32'(e.op.srcA), 32'(microOp.srcA));
            if (e.useSrcB)
                checkField("microOp.srcB", 32'(e.op.srcB), 32'(microOp.srcB));
            if (e.useImm)
                checkField("microOp.imm", e.op.imm, microOp.imm);
            checkField("microOp.isRASPush", 32'(e.op.isRASPush), 32'(microOp.isRASPush));
            checkField("microOp.isRASPop", 32'(e.op.isRASPop), 32'(microOp.isRASPop));
            case (e.op.mopType)
                MOP_ALU: checkField("microOp.aluCode", 32'(e.op.aluCode), 32'(microOp.aluCode));
                MOP_SHIFT: begin
                    checkField("microOp.shiftKind", 32'(e.op.shiftKind),
                               32'(microOp.shiftKind));
                    if (e.op.opTypeB == OPK_IMM)
                        checkField("microOp.shamt", 32'(e.op.shamt), 32'(microOp.shamt));
                end
                MOP_BR: checkField("microOp.cond", 32'(e.op.cond), 32'(microOp.cond));
                MOP_LOAD, MOP_STORE:
                    checkField("microOp.memMode", {29'd0, e.op.memMode}, {29'd0, microOp.memMode});
                default: ;
            endcase
        end
    endtask

    // Inputs are stable at the rising edge, so capture them here
    always @(posedge clk) begin
        if (!rst)
            expQ.push_back(expectFor(insn, illegalPC, inValid));
    end

    // Head of the queue lines up with the output 3 cycles after capture
    always @(negedge clk) begin : compareOutputs
        expectT e;
        e = '0;
        if (expQ.size() >= 3)
            e = expQ.pop_front();
        if (expQ.size() > 0) begin
            checkField("microOp.valid", 32'(e.op.valid), 32'(microOp.valid));
            if (e.op.valid) begin
                seenOutput = 1'b1;
                checkedCount++;
                compareOp(e);
            end else if (!seenOutput) begin
                checkField("insnInfo", 32'd0, {27'd0, insnInfo});
            end
        end
    end

    function automatic insnT randomInsn(input logic [6:0] opc);
        insnT w;
        w      = $urandom();
        w[6:0] = opc;
        return w;
    endfunction

    // x0, the link register or an ordinary register
    function automatic regNumT pickHintReg(input int sel);
        return (sel % 3 == 0) ? `ZERO_REG : (sel % 3 == 1) ? `LINK_REG : 5'd5;
    endfunction

    task automatic issue(input insnT w, input logic badPC);
        @(negedge clk);
        inValid   = 1'b1;
        insn      = w;
        illegalPC = badPC;
        issuedCount++;
    endtask

    task automatic idle();
        @(negedge clk);
        inValid   = 1'b0;
        insn      = $urandom();
        illegalPC = 1'b0;
    endtask

    task automatic finishTest(input string name);
        int cycles;
        int errors;
        idle();
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (checkedCount != issuedCount && cycles < 20);
        if (checkedCount != issuedCount) begin
            $display("Timed out with %0d micro-ops never seen", issuedCount - checkedCount);
            errorCount++;
        end
        errors    = errorCount - errorMark;
        errorMark = errorCount;
        testCount++;
        if (errors != 0)
            failedTests++;
        $display("test %0d %s: %s, %0d errors", testCount, name,
                 (errors == 0) ? "ok" : "FAILED", errors);
    endtask

    initial begin : stimulus
        int   i;
        int   f;
        insnT w;
        seedDummy = $urandom(35);
        clk       = 1'b0;
        rst       = 1'b1;
        inValid   = 1'b0;
        insn      = '0;
        illegalPC = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // Every third slot is a bubble
        for (i = 0; i < 12; i++) begin
            if (i % 3 == 2)
                idle();
            else
                issue(randomInsn(OPC_OP_IMM), 1'b0);
        end
        finishTest("reset, latency and gaps");

        for (i = 0; i < 60; i++) begin
            w = randomInsn((i % 2 == 0) ? OPC_OP : OPC_OP_IMM);
            if (i % 2 == 0 || w[13:12] == 2'b01)
                w[31:25] = ($urandom() % 2 == 0) ? 7'h00 : 7'h20;
            if (i % 6 == 0)
                w[11:7] = `ZERO_REG;
            issue(w, 1'b0);
        end
        finishTest("OP and OP-IMM");

        for (i = 0; i < 48; i++) begin
            case (i % 4)
                0: w = randomInsn(OPC_LUI);
                1: w = randomInsn(OPC_AUIPC);
                2: begin
                    w = randomInsn(OPC_LOAD);
                    f = $urandom_range(0, 4);
                    w[14:12] = 3'((f > 2) ? f + 1 : f);
                end
                default: begin
                    w = randomInsn(OPC_STORE);
                    w[14:12] = 3'($urandom_range(0, 2));
                end
            endcase
            if (i % 7 == 0)
                w[11:7] = `ZERO_REG;
            issue(w, 1'b0);
        end
        finishTest("upper immediates and memory");

        // Jumps walk through every rd and rs1 pairing of x0, x1 and x5
        for (i = 0; i < 45; i++) begin
            case (i % 3)
                0: begin
                    w = randomInsn(OPC_BRANCH);
                    f = $urandom_range(0, 5);
                    w[14:12] = 3'((f > 1) ? f + 2 : f);
                end
                1: begin
                    w = randomInsn(OPC_JAL);
                    w[11:7] = pickHintReg(i / 3);
                end
                default: begin
                    w = randomInsn(OPC_JALR);
                    w[11:7]   = pickHintReg(i / 3);
                    w[19:15]  = pickHintReg(i / 9);
                    w[14:12]  = 3'd0;
                end
            endcase
            issue(w, 1'b0);
        end
        finishTest("branches and jumps");

        for (i = 0; i < 64; i++) begin
            case (i % 8)
                0: w = randomInsn(7'b0001111);
                1: w = randomInsn(7'b1110011);
                2: w = $urandom();
                3: begin
                    w = randomInsn(OPC_BRANCH);
                    w[14:12] = 3'($urandom_range(2, 3));
                end
                4: begin
                    w = randomInsn(OPC_LOAD);
                    w[14:12] = (i % 3 == 0) ? 3'd3 : 3'($urandom_range(6, 7));
                end
                5: begin
                    w = randomInsn(OPC_STORE);
                    w[14:12] = 3'($urandom_range(3, 7));
                end
                6: begin
                    w = randomInsn(OPC_JALR);
                    w[14:12] = 3'($urandom_range(1, 7));
                end
                default: w = randomInsn(OPC_OP);
            endcase
            issue(w, 1'b0);
        end
        // Fetch violation wins over any encoding
        for (i = 0; i < 20; i++)
            issue((i % 2 == 0) ? randomInsn(OPC_JAL) : $urandom(), 1'b1);
        finishTest("exceptions");

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- rvDecoder.f
+incdir+.
rvDecodePkg.sv
insnFieldSplit.sv
opDecodeStage.sv
illegalCheckStage.sv
rvDecoder.sv
rvDecoderTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the decoder testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --top-module rvDecoderTb -f rvDecoder.f \
    -o rvDecoderSim > build.log 2>&1 \
    && ./obj_dir/rvDecoderSim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "sim passed" sim.log || { echo "no result in log"; exit 1; }
echo "PASS"
